// ==== filelist.f ====
hdl/ooo_pkg.sv
hdl/instr_queue.sv
hdl/regfile_scoreboard.sv
hdl/alu_rs.sv
hdl/rob.sv
hdl/cpu.sv
sim/cpu_props.sv
sim/cpu_tb.sv

// ==== hdl/alu_rs.sv ====
`timescale 1ns/1ps
module alu_rs
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  alu_op_t  issue_op,
  input  word_t    issue_imm,
  input  logic     issue_use_imm,
  input  rob_tag_t issue_tag,
  input  logic     rs1_rf_ready,
  input  logic     rs2_rf_ready,
  input  word_t    rs1_rf_v,
  input  word_t    rs2_rf_v,
  input  rob_tag_t rs1_rf_tag,
  input  rob_tag_t rs2_rf_tag,
  input  logic     rs1_rob_ready,
  input  logic     rs2_rob_ready,
  input  word_t    rs1_rob_v,
  input  word_t    rs2_rob_v,
  output logic     rs_full,
  output logic     cdb_valid,
  output rob_tag_t cdb_tag,
  output word_t    cdb_v
);

  logic [RS_ENTRIES-1:0] slot_valid;
  logic [RS_ENTRIES-1:0] op1_rdy;
  logic [RS_ENTRIES-1:0] op2_rdy;
  logic [RS_ENTRIES-1:0] eligible;
  logic [RS_ENTRIES-1:0] wake1;
  logic [RS_ENTRIES-1:0] wake2;
  alu_op_t               slot_op  [RS_ENTRIES];
  word_t                 op1_v    [RS_ENTRIES];
  word_t                 op2_v    [RS_ENTRIES];
  rob_tag_t              op1_tag  [RS_ENTRIES];
  rob_tag_t              op2_tag  [RS_ENTRIES];
  rob_tag_t              dest_tag [RS_ENTRIES];
  logic [RS_IDX_W-1:0]   sel;
  logic [RS_IDX_W-1:0]   free_slot;
  logic                  sel_found;
  logic                  src1_rdy;
  logic                  src2_rdy;
  word_t                 src1_v;
  word_t                 src2_v;
  word_t                 result;

  // operand present in regfile, in a done rob entry, or on the cdb right now
  function automatic logic operand_ready(logic rf_rdy, logic rob_rdy, rob_tag_t tag);
    return rf_rdy || rob_rdy || (cdb_valid && cdb_tag == tag);
  endfunction

  function automatic word_t operand_value(logic rf_rdy, word_t rf_v, logic rob_rdy,
                                          word_t rob_v);
    if (rf_rdy) return rf_v;
    if (rob_rdy) return rob_v;
    return cdb_v;
  endfunction

  function automatic word_t alu(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      default:  return b;
    endcase
  endfunction

  always_comb begin
    src1_rdy = operand_ready(rs1_rf_ready, rs1_rob_ready, rs1_rf_tag);
    src1_v   = operand_value(rs1_rf_ready, rs1_rf_v, rs1_rob_ready, rs1_rob_v);
    src2_rdy = issue_use_imm || operand_ready(rs2_rf_ready, rs2_rob_ready, rs2_rf_tag);
    src2_v   = issue_use_imm ? issue_imm
                             : operand_value(rs2_rf_ready, rs2_rf_v, rs2_rob_ready, rs2_rob_v);
  end

  assign rs_full   = &slot_valid;
  assign eligible  = slot_valid & op1_rdy & op2_rdy;
  assign sel_found = |eligible;
  assign result    = alu(slot_op[sel], op1_v[sel], op2_v[sel]);

  // lowest slot wins, both for selection and allocation
  always_comb begin
    sel       = '0;
    free_slot = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (eligible[i]) sel = RS_IDX_W'(i);
      if (!slot_valid[i]) free_slot = RS_IDX_W'(i);
    end
  end

  always_comb begin
    for (int i = 0; i < RS_ENTRIES; i++) begin
      wake1[i] = cdb_valid && slot_valid[i] && !op1_rdy[i] && op1_tag[i] == cdb_tag;
      wake2[i] = cdb_valid && slot_valid[i] && !op2_rdy[i] && op2_tag[i] == cdb_tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid <= '0;
      op1_rdy    <= '0;
      op2_rdy    <= '0;
      cdb_valid  <= 1'b0;
    end else begin
      cdb_valid <= sel_found;
      if (sel_found) slot_valid[sel] <= 1'b0;
      op1_rdy <= op1_rdy | wake1;
      op2_rdy <= op2_rdy | wake2;
      if (issue_valid) begin
        slot_valid[free_slot] <= 1'b1;
        op1_rdy[free_slot]    <= src1_rdy;
        op2_rdy[free_slot]    <= src2_rdy;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sel_found) begin
      cdb_tag <= dest_tag[sel];
      cdb_v   <= result;
    end
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (wake1[i]) op1_v[i] <= cdb_v;
      if (wake2[i]) op2_v[i] <= cdb_v;
    end
    if (issue_valid) begin
      slot_op[free_slot]  <= issue_op;
      op1_v[free_slot]    <= src1_v;
      op2_v[free_slot]    <= src2_v;
      op1_tag[free_slot]  <= rs1_rf_tag;
      op2_tag[free_slot]  <= rs2_rf_tag;
      dest_tag[free_slot] <= issue_tag;
    end
  end

endmodule : alu_rs

// ==== hdl/cpu.sv ====
`timescale 1ns/1ps
module cpu
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_valid,
  input  word_t    instr,
  output logic     instr_ready,
  output logic     commit_valid,
  output reg_idx_t commit_rd_s,
  output word_t    commit_rd_v,
  output order_t   commit_order
);

  // issue bus
  logic     issue_valid;
  alu_op_t  issue_op;
  reg_idx_t issue_rd_s;
  reg_idx_t issue_rs1_s;
  reg_idx_t issue_rs2_s;
  word_t    issue_imm;
  logic     issue_use_imm;
  rob_tag_t issue_tag;
  logic     rs_full;
  logic     rob_full;

  // operand lookup
  logic     rs1_rf_ready;
  logic     rs2_rf_ready;
  word_t    rs1_rf_v;
  word_t    rs2_rf_v;
  rob_tag_t rs1_rf_tag;
  rob_tag_t rs2_rf_tag;
  logic     rs1_rob_ready;
  logic     rs2_rob_ready;
  word_t    rs1_rob_v;
  word_t    rs2_rob_v;

  // single cdb from the alu station
  logic     cdb_valid;
  rob_tag_t cdb_tag;
  word_t    cdb_v;
  rob_tag_t commit_tag;

  instr_queue instr_queue (.*);

  regfile_scoreboard regfile_scoreboard (.*, .rob_commit(commit_valid));

  alu_rs alu_rs (.*);

  rob rob (.*, .rob_commit(commit_valid));

endmodule : cpu

// ==== hdl/instr_queue.sv ====
`timescale 1ns/1ps
module instr_queue
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     instr_valid,
  input  word_t    instr,
  input  logic     rs_full,
  input  logic     rob_full,
  output logic     instr_ready,
  output logic     issue_valid,
  output alu_op_t  issue_op,
  output reg_idx_t issue_rd_s,
  output reg_idx_t issue_rs1_s,
  output reg_idx_t issue_rs2_s,
  output word_t    issue_imm,
  output logic     issue_use_imm
);

  word_t               fifo_mem [IQ_ENTRIES];
  logic [IQ_DEPTH-1:0] head;
  logic [IQ_DEPTH-1:0] tail;
  logic [IQ_DEPTH:0]   count;
  logic                push;
  word_t               head_word;
  logic [6:0]          opcode;
  logic [2:0]          funct3;

  assign instr_ready = count != (IQ_DEPTH + 1)'(IQ_ENTRIES);
  assign push        = instr_valid && instr_ready;
  // pop only when both rs and rob have room
  assign issue_valid = (count != '0) && !rs_full && !rob_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + 1'b1;
      if (issue_valid) head <= head + 1'b1;
      count <= count + (IQ_DEPTH + 1)'(push) - (IQ_DEPTH + 1)'(issue_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo_mem[tail] <= instr;
  end

  // decode of the head word
  assign head_word = fifo_mem[head];
  assign opcode    = head_word[6:0];
  assign funct3    = head_word[14:12];

  assign issue_rd_s    = head_word[11:7];
  assign issue_rs1_s   = (opcode == OPC_LUI) ? '0 : head_word[19:15];
  assign issue_rs2_s   = (opcode == OPC_OP) ? head_word[24:20] : '0;
  assign issue_use_imm = (opcode == OPC_OP_IMM) || (opcode == OPC_LUI);
  assign issue_imm     = (opcode == OPC_LUI) ? {head_word[31:12], 12'b0}
                                             : {{20{head_word[31]}}, head_word[31:20]};

  always_comb begin
    case (funct3)
      3'b000:  issue_op = (opcode == OPC_OP && head_word[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  issue_op = ALU_SLL;
      3'b010:  issue_op = ALU_SLT;
      3'b011:  issue_op = ALU_SLTU;
      3'b100:  issue_op = ALU_XOR;
      3'b101:  issue_op = head_word[30] ? ALU_SRA : ALU_SRL;
      3'b110:  issue_op = ALU_OR;
      default: issue_op = ALU_AND;
    endcase
    if (opcode == OPC_LUI) issue_op = ALU_PASS_B;
  end

endmodule : instr_queue

// ==== hdl/ooo_pkg.sv ====
package ooo_pkg;

  // sizes
  localparam int ROB_DEPTH   = 3;
  localparam int ROB_ENTRIES = 2 ** ROB_DEPTH;
  localparam int RS_ENTRIES  = 4;
  localparam int RS_IDX_W    = $clog2(RS_ENTRIES);
  localparam int IQ_DEPTH    = 2;
  localparam int IQ_ENTRIES  = 2 ** IQ_DEPTH;
  localparam int REG_COUNT   = 32;

  typedef logic [31:0]          word_t;
  typedef logic [4:0]           reg_idx_t;
  typedef logic [ROB_DEPTH-1:0] rob_tag_t;
  typedef logic [31:0]          order_t;
  typedef logic [3:0]           alu_op_t;

  // rv32i major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // internal alu ops
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  // lui passes the upper immediate through
  localparam alu_op_t ALU_PASS_B = 4'd10;

endpackage : ooo_pkg

// ==== hdl/regfile_scoreboard.sv ====
`timescale 1ns/1ps
module regfile_scoreboard
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  reg_idx_t issue_rd_s,
  input  rob_tag_t issue_tag,
  input  reg_idx_t issue_rs1_s,
  input  reg_idx_t issue_rs2_s,
  input  logic     rob_commit,
  input  reg_idx_t commit_rd_s,
  input  word_t    commit_rd_v,
  input  rob_tag_t commit_tag,
  output logic     rs1_rf_ready,
  output logic     rs2_rf_ready,
  output word_t    rs1_rf_v,
  output word_t    rs2_rf_v,
  output rob_tag_t rs1_rf_tag,
  output rob_tag_t rs2_rf_tag
);

  word_t                regs [REG_COUNT];
  rob_tag_t             tags [REG_COUNT];
  logic [REG_COUNT-1:0] busy;
  logic                 rename_we;
  logic                 commit_we;

  assign rename_we = issue_valid && (issue_rd_s != '0);
  assign commit_we = rob_commit && (commit_rd_s != '0);

  // lookups at issue
  assign rs1_rf_ready = !busy[issue_rs1_s];
  assign rs2_rf_ready = !busy[issue_rs2_s];
  assign rs1_rf_v     = regs[issue_rs1_s];
  assign rs2_rf_v     = regs[issue_rs2_s];
  assign rs1_rf_tag   = tags[issue_rs1_s];
  assign rs2_rf_tag   = tags[issue_rs2_s];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      busy <= '0;
    end else begin
      if (commit_we) begin
        regs[commit_rd_s] <= commit_rd_v;
        // a newer producer keeps the register busy
        if (tags[commit_rd_s] == commit_tag) busy[commit_rd_s] <= 1'b0;
      end
      // rename after release so a same-cycle issue wins
      if (rename_we) busy[issue_rd_s] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rename_we) tags[issue_rd_s] <= issue_tag;
  end

endmodule : regfile_scoreboard

// ==== hdl/rob.sv ====
`timescale 1ns/1ps
module rob
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  reg_idx_t issue_rd_s,
  input  rob_tag_t rs1_rf_tag,
  input  rob_tag_t rs2_rf_tag,
  input  logic     cdb_valid,
  input  rob_tag_t cdb_tag,
  input  word_t    cdb_v,
  output logic     rob_full,
  output rob_tag_t issue_tag,
  output logic     rs1_rob_ready,
  output logic     rs2_rob_ready,
  output word_t    rs1_rob_v,
  output word_t    rs2_rob_v,
  output logic     rob_commit,
  output reg_idx_t commit_rd_s,
  output word_t    commit_rd_v,
  output rob_tag_t commit_tag,
  output order_t   commit_order
);

  reg_idx_t               entry_rd [ROB_ENTRIES];
  word_t                  entry_v  [ROB_ENTRIES];
  logic [ROB_ENTRIES-1:0] entry_done;
  rob_tag_t               head;
  rob_tag_t               tail;
  logic [ROB_DEPTH:0]     count;

  assign rob_full  = count == (ROB_DEPTH + 1)'(ROB_ENTRIES);
  assign issue_tag = tail;

  // operand lookup by the tag the scoreboard holds
  assign rs1_rob_ready = entry_done[rs1_rf_tag];
  assign rs2_rob_ready = entry_done[rs2_rf_tag];
  assign rs1_rob_v     = entry_v[rs1_rf_tag];
  assign rs2_rob_v     = entry_v[rs2_rf_tag];

  // in-order retire of the head
  assign rob_commit  = (count != '0) && entry_done[head];
  assign commit_tag  = head;
  assign commit_rd_s = entry_rd[head];
  assign commit_rd_v = (entry_rd[head] == '0) ? '0 : entry_v[head];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      entry_done   <= '0;
      commit_order <= '0;
    end else begin
      if (issue_valid) begin
        entry_done[tail] <= 1'b0;
        tail             <= tail + 1'b1;
      end
      if (cdb_valid) entry_done[cdb_tag] <= 1'b1;
      if (rob_commit) begin
        head         <= head + 1'b1;
        commit_order <= commit_order + 1'b1;
      end
      count <= count + (ROB_DEPTH + 1)'(issue_valid) - (ROB_DEPTH + 1)'(rob_commit);
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) entry_rd[tail] <= issue_rd_s;
    if (cdb_valid) entry_v[cdb_tag] <= cdb_v;
  end

endmodule : rob

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module cpu_tb -o cpu_sim > build.log 2>&1 &&
./obj_dir/cpu_sim > sim.log 2>&1 &&
grep -q "Everything OK" sim.log &&
echo "PASS" ||
{ echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== sim/cpu_props.sv ====
`timescale 1ns/1ps
module cpu_props
  import ooo_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     issue_valid,
  input logic     rob_full,
  input logic     rob_commit,
  input rob_tag_t head,
  input rob_tag_t tail,
  input order_t   commit_order
);

  // nothing retires from an empty buffer
  commit_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rob_commit |-> (head != tail) || rob_full)
    else $error("rob commit while the buffer is empty");

  issue_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |-> !rob_full)
    else $error("issue accepted while the rob is full");

  // retirement counter steps by one per commit
  order_step: assert property (@(posedge clk) disable iff (!rst_n)
    rob_commit |=> commit_order == $past(commit_order) + 1)
    else $error("commit_order did not step by one");

endmodule : cpu_props

bind rob cpu_props rob_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .issue_valid  (issue_valid),
  .rob_full     (rob_full),
  .rob_commit   (rob_commit),
  .head         (head),
  .tail         (tail),
  .commit_order (commit_order)
);

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
module cpu_tb
  import ooo_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int TOTAL_INSTR  = 250;

  logic     clk;
  logic     rst_n;
  logic     instr_valid;
  word_t    instr;
  logic     instr_ready;
  logic     commit_valid;
  reg_idx_t commit_rd_s;
  word_t    commit_rd_v;
  order_t   commit_order;

  // in-order reference state
  word_t    ref_regs [32];
  reg_idx_t exp_rd [$];
  word_t    exp_v [$];
  string    exp_name [$];
  order_t   exp_order;
  string    test_name;
  word_t    rng_state = 98;
  int       checks;
  int       errors;
  reg_idx_t e_rd;
  word_t    e_v;
  string    e_name;

  cpu UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                  reg_idx_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  function automatic word_t next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // sequential rv32i semantics on the reference registers
  function automatic word_t model_result(word_t w);
    word_t a;
    word_t b;
    logic [4:0] sh;
    if (w[6:0] == OPC_LUI) return {w[31:12], 12'b0};
    a  = ref_regs[w[19:15]];
    b  = (w[6:0] == OPC_OP) ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    sh = b[4:0];
    case (w[14:12])
      3'd0:    return (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return w[30] ? word_t'($signed(a) >>> sh) : a >> sh;
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic word_t random_instr();
    word_t       r;
    word_t       imm;
    logic [6:0]  f7;
    logic [11:0] imm12;
    r   = next_rand();
    imm = next_rand();
    f7  = ((r[17:15] == 3'b000 || r[17:15] == 3'b101) && r[21]) ? 7'b0100000 : 7'b0;
    case (r[20:18])
      3'd3, 3'd4, 3'd5: begin
        imm12 = imm[11:0];
        // shift immediates carry only a shamt and the arithmetic bit
        if (r[17:15] == 3'b001) imm12 = {7'b0, imm[4:0]};
        if (r[17:15] == 3'b101) imm12 = {r[21] ? 7'b0100000 : 7'b0, imm[4:0]};
        return enc_i(imm12, r[9:5], r[17:15], r[4:0]);
      end
      3'd6:    return enc_u(imm[31:12], r[4:0]);
      default: return enc_r(f7, r[14:10], r[9:5], r[17:15], r[4:0]);
    endcase
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // holds the word until the queue takes it
  task automatic send(input word_t w);
    word_t    v;
    reg_idx_t rd;
    rd = w[11:7];
    v  = model_result(w);
    if (rd == '0) v = '0;
    else ref_regs[rd] = v;
    exp_rd.push_back(rd);
    exp_v.push_back(v);
    exp_name.push_back(test_name);
    instr_valid = 1'b1;
    instr       = w;
    while (!instr_ready) idle(1);
    idle(1);
    instr_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_rd.size() != 0) idle(1);
  endtask

  always @(negedge clk) begin
    if (rst_n && commit_valid) begin
      assert (exp_rd.size() != 0) else begin
        errors++;
        $display("commit seen with no instruction outstanding, order %0d", commit_order);
      end
      if (exp_rd.size() != 0) begin
        e_rd   = exp_rd.pop_front();
        e_v    = exp_v.pop_front();
        e_name = exp_name.pop_front();
        checks += 3;
        assert (commit_rd_s == e_rd) else begin
          errors++;
          $display("Error %s rd: expected %0d actual %0d", e_name, e_rd, commit_rd_s);
        end
        assert (commit_rd_v == e_v) else begin
          errors++;
          $display("Error %s value: expected %h actual %h", e_name, e_v, commit_rd_v);
        end
        assert (commit_order == exp_order) else begin
          errors++;
          $display("Error %s order: expected %0d actual %0d", e_name, exp_order,
                   commit_order);
        end
        exp_order++;
      end
    end
  end

  task automatic test_reset();
    test_name = "reset";
    checks += 2;
    assert (!commit_valid) else begin
      errors++;
      $display("Error %s commit_valid: expected 0 actual %b", test_name, commit_valid);
    end
    assert (instr_ready) else begin
      errors++;
      $display("Error %s instr_ready: expected 1 actual %b", test_name, instr_ready);
    end
    // any commit here is caught by the monitor
    idle(20);
  endtask

  task automatic test_imm_ops();
    test_name = "imm_ops";
    send(enc_i(12'hffb, 5'd0, 3'b000, 5'd1));
    send(enc_i(12'h003, 5'd1, 3'b010, 5'd2));
    send(enc_i(12'h003, 5'd1, 3'b011, 5'd3));
    send(enc_i(12'h055, 5'd1, 3'b100, 5'd4));
    send(enc_i(12'h123, 5'd0, 3'b110, 5'd5));
    send(enc_i(12'h0f0, 5'd1, 3'b111, 5'd6));
    send(enc_i(12'h004, 5'd1, 3'b001, 5'd7));
    send(enc_i(12'h003, 5'd1, 3'b101, 5'd8));
    send(enc_i(12'h402, 5'd1, 3'b101, 5'd9));
    send(enc_u(20'habcde, 5'd10));
    wait_drain();
  endtask

  task automatic test_reg_chain();
    test_name = "reg_chain";
    send(enc_u(20'h12345, 5'd11));
    send(enc_i(12'h678, 5'd11, 3'b000, 5'd11));
    send(enc_i(12'h007, 5'd0, 3'b000, 5'd12));
    send(enc_r(7'h00, 5'd12, 5'd11, 3'b000, 5'd13));
    send(enc_r(7'h20, 5'd12, 5'd13, 3'b000, 5'd14));
    send(enc_r(7'h00, 5'd12, 5'd14, 3'b001, 5'd15));
    send(enc_r(7'h00, 5'd14, 5'd15, 3'b010, 5'd16));
    send(enc_r(7'h00, 5'd15, 5'd16, 3'b011, 5'd17));
    send(enc_r(7'h00, 5'd15, 5'd17, 3'b100, 5'd18));
    send(enc_r(7'h00, 5'd12, 5'd18, 3'b101, 5'd19));
    send(enc_r(7'h20, 5'd12, 5'd19, 3'b101, 5'd20));
    send(enc_r(7'h00, 5'd13, 5'd20, 3'b110, 5'd21));
    send(enc_r(7'h00, 5'd13, 5'd21, 3'b111, 5'd22));
    // gaps let the producer finish in the rob before the reader issues
    idle(3);
    send(enc_r(7'h00, 5'd11, 5'd22, 3'b000, 5'd23));
    idle(3);
    send(enc_r(7'h20, 5'd12, 5'd23, 3'b000, 5'd24));
    wait_drain();
  endtask

  task automatic test_x0_rename();
    test_name = "x0_rename";
    send(enc_i(12'h037, 5'd0, 3'b000, 5'd0));
    send(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd25));
    send(enc_i(12'h001, 5'd0, 3'b000, 5'd26));
    send(enc_i(12'h002, 5'd0, 3'b000, 5'd26));
    send(enc_r(7'h00, 5'd26, 5'd26, 3'b000, 5'd27));
    wait_drain();
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    for (int i = 0; i < 20; i++) begin
      if (i % 2 == 0) send(enc_i(12'(i + 1), 5'd28, 3'b000, 5'd28));
      else send(enc_i(12'(i * 3), 5'd28, 3'b100, 5'd29));
    end
    wait_drain();
  endtask

  task automatic test_random();
    test_name = "random";
    for (int i = 0; i < 200; i++) begin
      send(random_instr());
    end
    wait_drain();
  endtask

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 200 * TOTAL_INSTR));
    $display("timeout: instructions still waiting to commit");
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_order   = '0;
    checks      = 0;
    errors      = 0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_imm_ops();
    test_reg_chain();
    test_x0_rename();
    test_backpressure();
    test_random();
    idle(5);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : cpu_tb
